/* pipelineCore.f */
+incdir+rtl
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/pipelineCore.sv
tests/writebackChecker.sv
tests/pipelineCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the pipelineCore testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

if ! verilator --binary --timing -f pipelineCore.f --top-module pipelineCoreTb; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VpipelineCoreTb 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
	echo "Simulation passed"
	exit 0
fi

echo "Pass line not found in simulation output"
exit 1

/* tests/pipelineCoreTb.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module pipelineCoreTb;

	localparam int INIT_LEN = 7; // One load for each of r1..r7
	localparam int CHAIN_LEN = 40;
	localparam int FORMS_LEN = 40; // Ten ops, two forms, two rounds
	localparam int RANDOM_LEN = 80;
	localparam int ZERO_LEN = 30;
	localparam int DRAIN_WORDS = 3; // Last write retires as the third filler is taken
	localparam int PHASES = 5;
	localparam int PROGRAM_LEN = INIT_LEN + CHAIN_LEN + FORMS_LEN + RANDOM_LEN + ZERO_LEN;
	// Stalled phases need about two cycles per word, the steady ones one
	localparam int CYCLE_LIMIT = 2 * PROGRAM_LEN + PHASES * (DRAIN_WORDS + 1) + 2;

	logic clk;
	logic reset;
	logic instrReady;
	cpuPkg::word_t instrData;
	cpuPkg::pcAddr_t instrAddr;
	cpuPkg::wbPort_t wb;
	logic phaseDone;
	int phaseNum;
	int errorCount;
	int writeCount;
	int cycles;
	logic [31:0] lfsr;
	cpuPkg::word_t progMem [256];
	logic [7:0] loadIdx; // Next free program slot

	pipelineCore UUT (
		.clk(clk),
		.reset(reset),
		.instrReady(instrReady),
		.instrData(instrData),
		.instrAddr(instrAddr),
		.wb(wb)
	);

	writebackChecker wbCheck (
		.clk(clk),
		.reset(reset),
		.instrReady(instrReady),
		.instrData(instrData),
		.instrAddr(instrAddr),
		.wb(wb),
		.phaseDone(phaseDone),
		.phaseNum(phaseNum),
		.errorCount(errorCount),
		.writeCount(writeCount)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, a phase never drained", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] takeBits(int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic cpuPkg::regAddr_t randReg(); // r0..r7, dense dependencies
		logic [31:0] bits;
		bits = takeBits(3);
		return {2'b00, bits[2:0]};
	endfunction

	function automatic cpuPkg::regAddr_t randDest();
		cpuPkg::regAddr_t r;
		r = randReg();
		return (r == '0) ? 5'd7 : r;
	endfunction

	function automatic logic [3:0] randOp();
		logic [31:0] bits;
		bits = takeBits(4);
		return (bits[3:0] >= 4'd10) ? bits[3:0] - 4'd10 : bits[3:0];
	endfunction

	function automatic logic [1:0] randSel();
		logic [31:0] bits;
		bits = takeBits(2);
		return (bits[1:0] == 2'd3) ? 2'd0 : bits[1:0]; // Code 3 folds to register
	endfunction

	// Fields that the form ignores are left random
	function automatic cpuPkg::word_t makeInstr(logic [3:0] op, logic [1:0] sel, logic regWrite,
			cpuPkg::regAddr_t rd, cpuPkg::regAddr_t ra, cpuPkg::regAddr_t rb);
		cpuPkg::instr_t f;
		logic [31:0] bits;
		bits = takeBits(15);
		f.rd = rd;
		f.ra = ra;
		if (sel == cpuPkg::selReg) begin
			f.rb = rb;
			{f.shamt, f.immLow} = bits[8:0];
		end else begin
			{f.rb, f.shamt, f.immLow} = bits[13:0]; // Immediate or shift amount
		end
		f.opcode = {regWrite, bits[14], sel, op}; // Bit 6 random
		return f;
	endfunction

	task automatic putWord(cpuPkg::word_t w);
		progMem[loadIdx] = w;
		loadIdx = loadIdx + 8'd1;
	endtask

	// Feeds words until every filled slot is taken, then strobes the checker
	task automatic runPhase(int num, logic stallBus);
		cpuPkg::pcAddr_t endAddr;
		logic [31:0] bits;
		for (int i = 0; i < DRAIN_WORDS; i++) begin
			putWord('0); // No-write filler
		end
		endAddr = cpuPkg::pcAddr_t'({loadIdx, 2'b00});
		while (instrAddr != endAddr) begin
			instrData = progMem[instrAddr[9:2]]; // Word address
			bits = stallBus ? takeBits(1) : 32'd1;
			instrReady = bits[0];
			@(negedge clk);
		end
		instrReady = 1'b0; // Pipe holds during the strobe
		phaseNum = num;
		phaseDone = 1'b1;
		@(negedge clk);
		phaseDone = 1'b0;
	endtask

	initial begin
		cpuPkg::regAddr_t prevRd;
		cpuPkg::regAddr_t olderRd;
		cpuPkg::regAddr_t rd;
		logic [31:0] bits;
		logic [3:0] badOp;
		clk = 1'b0;
		reset = 1'b1;
		instrReady = 1'b0;
		instrData = '0;
		phaseDone = 1'b0;
		phaseNum = 0;
		cycles = 0;
		lfsr = 32'hf37f6692;
		loadIdx = '0;
		for (int i = 0; i < 256; i++) begin
			progMem[8'(i)] = '0;
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// Give r1..r7 known values from r0 plus an immediate
		for (int i = 1; i <= INIT_LEN; i++) begin
			putWord(makeInstr(4'd0, cpuPkg::selImm, 1'b1, cpuPkg::regAddr_t'(i), '0, '0));
		end
		runPhase(1, 1'b0);

		// Each word reads the last two results, distance 1 and 2
		prevRd = 5'd7;
		olderRd = 5'd6;
		for (int i = 0; i < CHAIN_LEN; i++) begin
			rd = cpuPkg::regAddr_t'(1 + i % 7);
			putWord(makeInstr(randOp(), cpuPkg::selReg, 1'b1, rd, prevRd, olderRd));
			olderRd = prevRd;
			prevRd = rd;
		end
		runPhase(2, 1'b0);

		for (int round = 0; round < FORMS_LEN / 20; round++) begin
			for (int op = 0; op < 10; op++) begin
				putWord(makeInstr(4'(op), cpuPkg::selImm, 1'b1, randDest(), randDest(), '0));
				putWord(makeInstr(4'(op), cpuPkg::selShamt, 1'b1, randDest(), randDest(), '0));
			end
		end
		runPhase(3, 1'b0);

		for (int i = 0; i < RANDOM_LEN; i++) begin
			putWord(makeInstr(randOp(), randSel(), 1'b1, randReg(), randReg(), randReg()));
		end
		runPhase(4, 1'b1);

		// Writes to r0, unused ops and reads of r0 in turn
		for (int i = 0; i < ZERO_LEN; i++) begin
			case (i % 3)
				0: putWord(makeInstr(randOp(), randSel(), 1'b1, '0, randReg(), randReg()));
				1: begin
					bits = takeBits(3);
					badOp = (bits[2:0] < 3'd6) ? 4'd10 + {1'b0, bits[2:0]} : 4'd15;
					putWord(makeInstr(badOp, randSel(), 1'b1, randDest(), randReg(), randReg()));
				end
				default: putWord(makeInstr(randOp(), cpuPkg::selReg, 1'b1, randDest(), '0,
					randReg()));
			endcase
		end
		runPhase(5, 1'b1);

		@(negedge clk);
		$display("Totals: %0d phases, %0d writes checked, %0d errors", PHASES, writeCount,
			errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tests/writebackChecker.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module writebackChecker (
	input logic clk,
	input logic reset,
	input logic instrReady,
	input cpuPkg::word_t instrData,
	input cpuPkg::pcAddr_t instrAddr,
	input cpuPkg::wbPort_t wb,
	input logic phaseDone, // One-cycle strobe once a phase has drained
	input int phaseNum,
	output int errorCount,
	output int writeCount
);

	// One predicted write, tagged with the edge that fetched it
	typedef struct packed {
		cpuPkg::regAddr_t rd;
		cpuPkg::word_t data;
		logic [31:0] acceptIdx;
	} expected_t;

	cpuPkg::word_t model [`NUM_REGS]; // Register state in program order
	expected_t pending [$]; // Oldest write at the front
	logic [31:0] acceptCount; // Accepted edges since reset
	int phaseWrites;
	int phaseErrors;

	initial begin
		for (int i = 0; i < `NUM_REGS; i++) begin
			model[cpuPkg::regAddr_t'(i)] = '0;
		end
		acceptCount = '0;
		errorCount = 0;
		writeCount = 0;
		phaseWrites = 0;
		phaseErrors = 0;
	end

	function automatic cpuPkg::word_t readReg(cpuPkg::regAddr_t idx);
		if (idx == '0) begin
			return '0; // r0 reads zero
		end
		return model[idx];
	endfunction

	// Shift by a word or more leaves only the fill
	function automatic cpuPkg::word_t shiftRight(cpuPkg::word_t a, cpuPkg::word_t amt,
			logic arith);
		cpuPkg::word_t fill;
		cpuPkg::word_t shifted;
		fill = (arith && a[`WORD_WIDTH-1]) ? '1 : '0;
		if (amt >= `WORD_WIDTH) begin
			return fill;
		end
		shifted = a >> amt[`SHAMT_WIDTH-1:0];
		return shifted | (fill & ~({`WORD_WIDTH{1'b1}} >> amt[`SHAMT_WIDTH-1:0]));
	endfunction

	// Expected register write of one instruction word, valid low if none
	function automatic cpuPkg::wbPort_t predict(cpuPkg::word_t word);
		cpuPkg::instr_t f;
		logic [`IMM_WIDTH-1:0] imm;
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		cpuPkg::wbPort_t res;
		f = word;
		imm = {f.rb, f.shamt, f.immLow}; // Bits 21:8
		a = readReg(f.ra);
		case (f.opcode.sel)
			cpuPkg::selImm: b = {{(`WORD_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
			cpuPkg::selShamt: b = {{(`WORD_WIDTH - `SHAMT_WIDTH){1'b0}}, f.shamt};
			default: b = readReg(f.rb);
		endcase
		res.rd = f.rd;
		res.valid = f.opcode.regWrite && (f.opcode.op < 4'd10) && (f.rd != '0);
		case (f.opcode.op)
			cpuPkg::aluAdd: res.data = a + b;
			cpuPkg::aluSub: res.data = a - b;
			cpuPkg::aluMul: res.data = a * b; // Low word
			cpuPkg::aluXor: res.data = a ^ b;
			cpuPkg::aluOr: res.data = a | b;
			cpuPkg::aluAnd: res.data = a & b;
			cpuPkg::aluSll: res.data = (b >= `WORD_WIDTH) ? '0 : (a << b[`SHAMT_WIDTH-1:0]);
			cpuPkg::aluSra: res.data = shiftRight(a, b, 1'b1);
			cpuPkg::aluSrl: res.data = shiftRight(a, b, 1'b0);
			cpuPkg::aluSleu: res.data = (a <= b) ? 32'd1 : 32'd0; // Unsigned compare
			default: res.data = '0;
		endcase
		return res;
	endfunction

	// Signals change on the falling edge, so the rising edge sees them settled
	always @(posedge clk) begin
		expected_t head;
		expected_t entry;
		cpuPkg::wbPort_t next;
		if (reset) begin
			acceptCount = '0;
			pending.delete();
		end else begin
			if (instrAddr != cpuPkg::pcAddr_t'(acceptCount * `PC_STEP)) begin
				$display("Fail %0t ns: instrAddr is %h after %0d accepted words", $time,
					instrAddr, acceptCount);
				errorCount++;
				phaseErrors++;
			end
			// Retirement first, the head is always older than this edge's word
			if (wb.valid) begin
				if (pending.size() == 0) begin
					$display("Write to r%0d at %0t ns with no instruction left to retire",
						wb.rd, $time);
					errorCount++;
					phaseErrors++;
				end else begin
					head = pending.pop_front();
					writeCount++;
					phaseWrites++;
					if (wb.rd !== head.rd || wb.data !== head.data) begin
						$display("Fail %0t ns: wrote r%0d = %h, expected r%0d = %h", $time,
							wb.rd, wb.data, head.rd, head.data);
						errorCount++;
						phaseErrors++;
					end else if (acceptCount != head.acceptIdx + 3) begin
						$display("Write to r%0d retired %0d accepted edges after fetch, not 3",
							wb.rd, acceptCount - head.acceptIdx);
						errorCount++;
						phaseErrors++;
					end
				end
			end
			if (instrReady) begin
				next = predict(instrData);
				if (next.valid) begin
					model[next.rd] = next.data; // Later words see it at once
					entry.rd = next.rd;
					entry.data = next.data;
					entry.acceptIdx = acceptCount;
					pending.push_back(entry);
				end
				acceptCount++;
			end
			if (phaseDone) begin
				if (pending.size() != 0) begin
					$display("Phase %0d ended with %0d writes that never retired", phaseNum,
						pending.size());
					errorCount++;
					phaseErrors++;
					pending.delete();
				end
				$display("Phase %0d done: %0d writes checked, %0d errors", phaseNum,
					phaseWrites, phaseErrors);
				phaseWrites = 0;
				phaseErrors = 0;
			end
		end
	end

endmodule

/* rtl/pipelineCore.sv */
`timescale 1ns/1ns

module pipelineCore (
	input logic clk,
	input logic reset,
	input logic instrReady,
	input cpuPkg::word_t instrData,
	output cpuPkg::pcAddr_t instrAddr,
	output cpuPkg::wbPort_t wb
);

	logic advance; // Whole pipe moves together
	cpuPkg::ifId_t ifId;
	cpuPkg::idEx_t idEx;
	cpuPkg::exWb_t exWb;

	// Freeze everything while the instruction bus stalls
	assign advance = instrReady;

	fetchStage fetch (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.instrReady(instrReady),
		.instrData(instrData),
		.instrAddr(instrAddr),
		.ifId(ifId)
	);

	// Register file lives in decode, written back from execute
	decodeStage decode (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.ifId(ifId),
		.wbWrite(exWb),
		.idEx(idEx)
	);

	executeStage execute (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.idEx(idEx),
		.exWb(exWb),
		.wb(wb)
	);

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ns

module executeStage (
	input logic clk,
	input logic reset,
	input logic advance,
	input cpuPkg::idEx_t idEx,
	output cpuPkg::exWb_t exWb,
	output cpuPkg::wbPort_t wb
);

	logic fwdA;
	logic fwdB;
	cpuPkg::word_t opA; // After forwarding
	cpuPkg::word_t opB;
	cpuPkg::word_t aluOut;

	// Distance-1 dependency, the older result still sits in EX/WB
	// A write flag implies rd is nonzero, so r0 never matches
	assign fwdA = exWb.write && (exWb.rd == idEx.ra);
	assign fwdB = exWb.write && (exWb.rd == idEx.rb); // rb is 0 for imm/shamt forms

	assign opA = fwdA ? exWb.result : idEx.opA;
	assign opB = fwdB ? exWb.result : idEx.opB;

	always_comb begin
		case (idEx.op)
			cpuPkg::aluAdd: aluOut = opA + opB;
			cpuPkg::aluSub: aluOut = opA - opB;
			cpuPkg::aluMul: aluOut = opA * opB; // Low word kept
			cpuPkg::aluXor: aluOut = opA ^ opB;
			cpuPkg::aluOr: aluOut = opA | opB;
			cpuPkg::aluAnd: aluOut = opA & opB;
			cpuPkg::aluSll: aluOut = opA << opB;
			cpuPkg::aluSra: aluOut = $signed(opA) >>> opB; // Sign fills from the top
			cpuPkg::aluSrl: aluOut = opA >> opB;
			cpuPkg::aluSleu: aluOut = cpuPkg::word_t'(opA <= opB); // 1 or 0
			default: aluOut = '0; // Unused ops carry no write
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exWb.write <= 1'b0;
		end else if (advance) begin
			exWb.write <= idEx.regWrite;
			exWb.rd <= idEx.rd;
			exWb.result <= aluOut;
		end
	end

	// Valid only on the edge where the register file commits
	assign wb.valid = exWb.write && advance;
	assign wb.rd = exWb.rd;
	assign wb.data = exWb.result;

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module decodeStage (
	input logic clk,
	input logic reset,
	input logic advance,
	input cpuPkg::ifId_t ifId,
	input cpuPkg::exWb_t wbWrite,
	output cpuPkg::idEx_t idEx
);

	cpuPkg::instr_t fields;
	cpuPkg::imm_t imm;
	cpuPkg::word_t immExt;
	cpuPkg::word_t shamtExt;
	cpuPkg::regAddr_t readAddrB;
	cpuPkg::word_t readDataA;
	cpuPkg::word_t readDataB;
	logic opValid; // Operation field names a real ALU op
	logic fromReg; // Operand B is a register read
	cpuPkg::idEx_t idExNext;

	assign fields = ifId.instr;

	// Immediate spans rb, shamt and the low nibble
	assign imm = {fields.rb, fields.shamt, fields.immLow};
	assign immExt = {{(`WORD_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
	assign shamtExt = {{(`WORD_WIDTH - `SHAMT_WIDTH){1'b0}}, fields.shamt};

	assign opValid = fields.opcode.op <= cpuPkg::aluSleu; // 10..15 unused
	assign fromReg = (fields.opcode.sel != cpuPkg::selImm) &&
		(fields.opcode.sel != cpuPkg::selShamt); // Code 3 treated as register

	// Index zero here keeps execute from forwarding into an immediate
	assign readAddrB = fromReg ? fields.rb : '0;

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.readAddrA(fields.ra),
		.readAddrB(readAddrB),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.write(wbWrite),
		.advance(advance)
	);

	always_comb begin
		idExNext.ra = fields.ra;
		idExNext.rb = readAddrB;
		idExNext.rd = fields.rd;
		idExNext.op = fields.opcode.op;
		// Destination r0 and unused ops retire nothing
		idExNext.regWrite = fields.opcode.regWrite && opValid && (fields.rd != '0);
		idExNext.opA = readDataA;
		case (fields.opcode.sel)
			cpuPkg::selImm: idExNext.opB = immExt;
			cpuPkg::selShamt: idExNext.opB = shamtExt;
			default: idExNext.opB = readDataB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idEx.regWrite <= 1'b0; // Bubble
		end else if (advance) begin
			idEx <= idExNext;
		end
	end

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module registerFile (
	input logic clk,
	input logic reset,
	input cpuPkg::regAddr_t readAddrA,
	input cpuPkg::regAddr_t readAddrB,
	output cpuPkg::word_t readDataA,
	output cpuPkg::word_t readDataB,
	input cpuPkg::exWb_t write,
	input logic advance
);

	cpuPkg::word_t regs [`NUM_REGS]; // Entry 0 is never read
	logic commit; // Write lands at the coming edge

	assign commit = write.write && advance;

	// One read port, used twice
	function automatic cpuPkg::word_t lookup(cpuPkg::regAddr_t addr);
		if (addr == '0) begin
			return '0; // r0 hardwired
		end else if (commit && (addr == write.rd)) begin
			return write.result; // Write-through, decode sees it this cycle
		end
		return regs[addr];
	endfunction

	always_comb begin
		readDataA = lookup(readAddrA);
		readDataB = lookup(readAddrB);
	end

	// Rising-edge write, held off while reset is asserted
	always_ff @(posedge clk) begin
		if (commit && !reset) begin
			regs[write.rd] <= write.result;
		end
	end

endmodule

/* rtl/fetchStage.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module fetchStage (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic instrReady,
	input cpuPkg::word_t instrData,
	output cpuPkg::pcAddr_t instrAddr,
	output cpuPkg::ifId_t ifId
);

	cpuPkg::pcAddr_t pc;
	cpuPkg::pcAddr_t pcNext;
	logic accept; // Word on instrData is taken this edge

	// Bus handshake and pipe step coincide, both gate the fetch
	assign accept = advance && instrReady;
	assign pcNext = pc + cpuPkg::pcAddr_t'(`PC_STEP); // Straight-line code only
	assign instrAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifId.instr <= '0; // Opcode zero has no register write
		end else if (accept) begin
			pc <= pcNext;
			ifId.instr <= instrData;
		end
		// Otherwise PC and IF/ID hold through the freeze
	end

endmodule

/* rtl/cpuPkg.sv */
`include "cpu_cfg.svh"

package cpuPkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`PC_WIDTH-1:0] pcAddr_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
	typedef logic [`SHAMT_WIDTH-1:0] shamt_t;
	typedef logic [`IMM_WIDTH-1:0] imm_t;

	// ALU operation field, codes 10 to 15 are unused
	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluMul = 4'd2,
		aluXor = 4'd3,
		aluOr = 4'd4,
		aluAnd = 4'd5,
		aluSll = 4'd6,
		aluSra = 4'd7, // Signed shift
		aluSrl = 4'd8,
		aluSleu = 4'd9 // Unsigned a <= b
	} aluOp_e;

	// Source of the second ALU operand
	typedef enum logic [`OPERAND_SEL_WIDTH-1:0] {
		selReg = 2'd0,
		selImm = 2'd1,
		selShamt = 2'd2
	} operandSel_e;

	// Opcode byte, bits 7:0 of the instruction
	typedef struct packed {
		logic regWrite; // Bit 7
		logic ignored; // Bit 6, no meaning
		operandSel_e sel; // Bits 5:4
		aluOp_e op; // Bits 3:0
	} opcode_t;

	// Instruction word; the immediate is {rb, shamt, immLow}
	typedef struct packed {
		regAddr_t rd; // 31:27
		regAddr_t ra; // 26:22
		regAddr_t rb; // 21:17
		shamt_t shamt; // 16:12
		logic [`IMM_LOW_WIDTH-1:0] immLow; // 11:8
		opcode_t opcode; // 7:0
	} instr_t;

	typedef struct packed {
		word_t instr;
	} ifId_t;

	typedef struct packed {
		regAddr_t ra;
		regAddr_t rb; // Zero unless operand B came from a register
		regAddr_t rd;
		aluOp_e op;
		logic regWrite;
		word_t opA;
		word_t opB; // Already selected
	} idEx_t;

	typedef struct packed {
		logic write;
		regAddr_t rd;
		word_t result;
	} exWb_t;

	// Retired register write as seen outside the core
	typedef struct packed {
		logic valid;
		regAddr_t rd;
		word_t data;
	} wbPort_t;

endpackage

/* rtl/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath word
`define WORD_WIDTH 32

// Instruction side
`define PC_WIDTH 12 // Byte address into program space
`define PC_STEP 4 // One word per instruction

// Register file
`define REG_ADDR_WIDTH 5
`define NUM_REGS (1 << `REG_ADDR_WIDTH) // Full index range, r0 included

// Instruction fields
`define IMM_WIDTH 14 // Sign-extended to a word in decode
`define SHAMT_WIDTH 5 // Zero-extended to a word in decode

// Opcode byte fields
`define ALU_OP_WIDTH 4
`define OPERAND_SEL_WIDTH 2

// Low immediate bits below the shift amount field
`define IMM_LOW_WIDTH (`IMM_WIDTH - `REG_ADDR_WIDTH - `SHAMT_WIDTH)

`endif
